/* msr_pkg.sv */
/* Shared widths, MSR bank map, offset bits, PSR layout,
   reset values and read-only id constants of the MSR unit */
`default_nettype none

package msr_pkg;

   // Datapath widths
   localparam int unsigned dw          = 32;
   localparam int unsigned psr_dw      = 10;
   localparam int unsigned pc_w        = 30;
   localparam int unsigned tlb_aw      = 3;
   localparam int unsigned tlb_n       = 1 << tlb_aw;

   // MSR address split: bank field directly above offset field
   localparam int unsigned bank_aw     = 5;
   localparam int unsigned bank_off_aw = 9;

   // Bank numbers
   localparam logic [bank_aw-1:0] bank_ps   = bank_aw'(0);
   localparam logic [bank_aw-1:0] bank_imm  = bank_aw'(1);
   localparam logic [bank_aw-1:0] bank_dmm  = bank_aw'(2);
   // Not implemented here, these read back as zero
   localparam logic [bank_aw-1:0] bank_ica  = bank_aw'(3);
   localparam logic [bank_aw-1:0] bank_dca  = bank_aw'(4);
   localparam logic [bank_aw-1:0] bank_dbg  = bank_aw'(5);
   localparam logic [bank_aw-1:0] bank_irqc = bank_aw'(6);
   localparam logic [bank_aw-1:0] bank_tsc  = bank_aw'(7);

   // One-hot offset bits inside the PS bank
   localparam int unsigned off_psr    = 0;
   localparam int unsigned off_cpuid  = 1;
   localparam int unsigned off_epsr   = 2;
   localparam int unsigned off_epc    = 3;
   localparam int unsigned off_elsa   = 4;
   localparam int unsigned off_coreid = 5;

   // MMU bank offset bits
   // Clear tlbsel selects the MMU id word
   localparam int unsigned off_tlbsel   = 8;
   localparam int unsigned off_tlbh_sel = 7;

   // PSR field positions, remaining bits reserved
   localparam int unsigned psr_cc   = 0;
   localparam int unsigned psr_rm   = 4;
   localparam int unsigned psr_ire  = 5;
   localparam int unsigned psr_imme = 6;
   localparam int unsigned psr_dmme = 7;

   // Out of reset the core runs in root mode with everything else off
   localparam logic [psr_dw-1:0] psr_rst = psr_dw'(1) << psr_rm;

   // Read-only identification words
   localparam logic [dw-1:0] cpuid_val  = 32'h4d53_0101;
   localparam logic [dw-1:0] coreid_val = 32'h0000_0001;
   localparam logic [dw-1:0] immid_val  = 32'h0003_0001;
   localparam logic [dw-1:0] dmmid_val  = 32'h0003_0002;

endpackage : msr_pkg

`default_nettype wire

/* msr_eu.sv */
/* MSR execution unit: address decode, read data mux,
   write enables and next values for status and TLB registers */
`default_nettype none

module msr_eu
   import msr_pkg::*;
(
   input  wire logic              rmsr,
   input  wire logic              wmsr,
   input  wire logic [dw-1:0]     operand_1,
   input  wire logic [dw-1:0]     operand_2,
   input  wire logic [dw-1:0]     operand_3,
   input  wire logic              commit,
   input  wire logic              cc_we,
   input  wire logic              cc_nxt,
   input  wire logic              ret,
   input  wire logic              syscall,
   input  wire logic              specul_extexp,
   input  wire logic              let_lsa_pc,
   input  wire logic [pc_w-1:0]   insn_pc,
   input  wire logic [dw-1:0]     linkaddr,
   input  wire logic [psr_dw-1:0] psr,
   input  wire logic [psr_dw-1:0] epsr,
   input  wire logic [dw-1:0]     epc,
   input  wire logic [dw-1:0]     elsa,
   input  wire logic [dw-1:0]     itlbl,
   input  wire logic [dw-1:0]     itlbh,
   input  wire logic [dw-1:0]     dtlbl,
   input  wire logic [dw-1:0]     dtlbh,
   output logic                   dout_op,
   output logic [dw-1:0]          dout,
   output logic                   exp_ent,
   output logic                   psr_cc_nxt,
   output logic                   psr_cc_we,
   output logic                   psr_rm_nxt,
   output logic                   psr_rm_we,
   output logic                   psr_ire_nxt,
   output logic                   psr_ire_we,
   output logic                   psr_imme_nxt,
   output logic                   psr_imme_we,
   output logic                   psr_dmme_nxt,
   output logic                   psr_dmme_we,
   output logic [psr_dw-1:0]      epsr_nxt,
   output logic                   epsr_we,
   output logic [dw-1:0]          epc_nxt,
   output logic                   epc_we,
   output logic [dw-1:0]          elsa_nxt,
   output logic                   elsa_we,
   output logic [tlb_aw-1:0]      tlb_idx,
   output logic [dw-1:0]          tlb_wdat,
   output logic                   itlbl_we,
   output logic                   itlbh_we,
   output logic                   dtlbl_we,
   output logic                   dtlbh_we
);

   logic [dw-1:0]          msr_addr;
   logic [bank_aw-1:0]     bank;
   logic [bank_off_aw-1:0] off;
   logic                   sel_ps;
   logic                   sel_imm;
   logic                   sel_dmm;
   logic                   tlbl_sel;
   logic                   tlbh_sel;
   logic [dw-1:0]          dout_ps;
   logic [dw-1:0]          dout_imm;
   logic [dw-1:0]          dout_dmm;
   logic                   wmsr_psr_we;
   logic                   wmsr_epsr_we;
   logic                   wmsr_epc_we;
   logic                   wmsr_elsa_we;
   logic [dw-1:0]          lsa_pc;

   assign msr_addr = operand_1 + operand_2;
   assign bank     = msr_addr[bank_aw+bank_off_aw-1:bank_off_aw];
   assign off      = msr_addr[bank_off_aw-1:0];

   always_comb begin
      sel_ps  = 1'b0;
      sel_imm = 1'b0;
      sel_dmm = 1'b0;
      case (bank)
         bank_ps:  sel_ps  = 1'b1;
         bank_imm: sel_imm = 1'b1;
         bank_dmm: sel_dmm = 1'b1;
         // Unmapped banks leave every select low
         bank_ica, bank_dca, bank_dbg, bank_irqc, bank_tsc: ;
         default: ;
      endcase
   end

   // TLB word selects are shared by both MMU banks
   assign tlbl_sel = off[off_tlbsel] & ~off[off_tlbh_sel];
   assign tlbh_sel = off[off_tlbsel] & off[off_tlbh_sel];
   assign tlb_idx  = off[tlb_aw-1:0];
   assign tlb_wdat = operand_3;

   // Read path
   assign dout_op = rmsr;

   assign dout_ps = ({dw{off[off_psr]}}    & {{(dw-psr_dw){1'b0}}, psr})
                  | ({dw{off[off_cpuid]}}  & cpuid_val)
                  | ({dw{off[off_epsr]}}   & {{(dw-psr_dw){1'b0}}, epsr})
                  | ({dw{off[off_epc]}}    & epc)
                  | ({dw{off[off_elsa]}}   & elsa)
                  | ({dw{off[off_coreid]}} & coreid_val);

   assign dout_imm = ({dw{~off[off_tlbsel]}} & immid_val)
                   | ({dw{tlbl_sel}}         & itlbl)
                   | ({dw{tlbh_sel}}         & itlbh);

   assign dout_dmm = ({dw{~off[off_tlbsel]}} & dmmid_val)
                   | ({dw{tlbl_sel}}         & dtlbl)
                   | ({dw{tlbh_sel}}         & dtlbh);

   assign dout = ({dw{sel_ps}}  & dout_ps)
               | ({dw{sel_imm}} & dout_imm)
               | ({dw{sel_dmm}} & dout_dmm);

   // Write-MSR decode in the PS bank
   assign wmsr_psr_we  = wmsr & sel_ps & off[off_psr];
   assign wmsr_epsr_we = wmsr & sel_ps & off[off_epsr];
   assign wmsr_epc_we  = wmsr & sel_ps & off[off_epc];
   assign wmsr_elsa_we = wmsr & sel_ps & off[off_elsa];

   assign lsa_pc  = {insn_pc, 2'b00};
   assign exp_ent = commit & (syscall | specul_extexp);

   // PSR fields: flag update, then write-MSR, then return from EPSR
   assign psr_cc_nxt   = cc_we       ? cc_nxt :
                         wmsr_psr_we ? operand_3[psr_cc] : epsr[psr_cc];
   assign psr_cc_we    = commit & (ret | cc_we | wmsr_psr_we);
   assign psr_rm_nxt   = wmsr_psr_we ? operand_3[psr_rm] : epsr[psr_rm];
   assign psr_rm_we    = commit & (ret | wmsr_psr_we);
   assign psr_ire_nxt  = wmsr_psr_we ? operand_3[psr_ire] : epsr[psr_ire];
   assign psr_ire_we   = commit & (ret | wmsr_psr_we);
   assign psr_imme_nxt = wmsr_psr_we ? operand_3[psr_imme] : epsr[psr_imme];
   assign psr_imme_we  = commit & (ret | wmsr_psr_we);
   assign psr_dmme_nxt = wmsr_psr_we ? operand_3[psr_dmme] : epsr[psr_dmme];
   assign psr_dmme_we  = commit & (ret | wmsr_psr_we);

   // EPSR saves the PSR as it was before this cycle's update
   assign epsr_nxt = wmsr_epsr_we ? operand_3[psr_dw-1:0] : psr;
   assign epsr_we  = exp_ent | (commit & wmsr_epsr_we);

   // Syscall returns past itself, an external exception replays the faulting pc
   assign epc_nxt = wmsr_epc_we   ? operand_3 :
                    specul_extexp ? lsa_pc    : linkaddr;
   assign epc_we  = commit & (syscall | specul_extexp | wmsr_epc_we);

   assign elsa_nxt = let_lsa_pc ? lsa_pc : operand_3;
   assign elsa_we  = commit & (let_lsa_pc | wmsr_elsa_we);

   assign itlbl_we = commit & wmsr & sel_imm & tlbl_sel;
   assign itlbh_we = commit & wmsr & sel_imm & tlbh_sel;
   assign dtlbl_we = commit & wmsr & sel_dmm & tlbl_sel;
   assign dtlbh_we = commit & wmsr & sel_dmm & tlbh_sel;

   // Next-value muxes above rely on mutually exclusive sources
   always_comb begin
      if (commit) begin
         assert final ($onehot0({ret, syscall, specul_extexp, cc_we, wmsr_psr_we}))
            else $error("PSR write-back sources overlap in one committed cycle");
         assert final (!(wmsr_elsa_we && let_lsa_pc))
            else $error("ELSA write-MSR and fault capture in one committed cycle");
      end
   end

endmodule : msr_eu

`default_nettype wire

/* psr_regs.sv */
/* Processor status registers: PSR flags with exception entry,
   EPSR, EPC and ELSA */
`default_nettype none

module psr_regs
   import msr_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              psr_cc_nxt,
   input  wire logic              psr_cc_we,
   input  wire logic              psr_rm_nxt,
   input  wire logic              psr_rm_we,
   input  wire logic              psr_ire_nxt,
   input  wire logic              psr_ire_we,
   input  wire logic              psr_imme_nxt,
   input  wire logic              psr_imme_we,
   input  wire logic              psr_dmme_nxt,
   input  wire logic              psr_dmme_we,
   input  wire logic [psr_dw-1:0] epsr_nxt,
   input  wire logic              epsr_we,
   input  wire logic [dw-1:0]     epc_nxt,
   input  wire logic              epc_we,
   input  wire logic [dw-1:0]     elsa_nxt,
   input  wire logic              elsa_we,
   input  wire logic              exp_ent,
   output logic [psr_dw-1:0]      psr,
   output logic [psr_dw-1:0]      epsr,
   output logic [dw-1:0]          epc,
   output logic [dw-1:0]          elsa
);

   logic cc;
   logic rm;
   logic ire;
   logic imme;
   logic dmme;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cc   <= psr_rst[psr_cc];
         rm   <= psr_rst[psr_rm];
         ire  <= psr_rst[psr_ire];
         imme <= psr_rst[psr_imme];
         dmme <= psr_rst[psr_dmme];
      end else begin
         if (psr_cc_we) begin
            cc <= psr_cc_nxt;
         end
         // Exception entry forces root mode with irqs and MMUs off
         if (exp_ent) begin
            rm   <= 1'b1;
            ire  <= 1'b0;
            imme <= 1'b0;
            dmme <= 1'b0;
         end else begin
            if (psr_rm_we) begin
               rm <= psr_rm_nxt;
            end
            if (psr_ire_we) begin
               ire <= psr_ire_nxt;
            end
            if (psr_imme_we) begin
               imme <= psr_imme_nxt;
            end
            if (psr_dmme_we) begin
               dmme <= psr_dmme_nxt;
            end
         end
      end
   end

   // Reserved bits stay zero
   always_comb begin
      psr           = '0;
      psr[psr_cc]   = cc;
      psr[psr_rm]   = rm;
      psr[psr_ire]  = ire;
      psr[psr_imme] = imme;
      psr[psr_dmme] = dmme;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         epsr <= '0;
         epc  <= '0;
         elsa <= '0;
      end else begin
         if (epsr_we) begin
            epsr <= epsr_nxt;
         end
         if (epc_we) begin
            epc <= epc_nxt;
         end
         if (elsa_we) begin
            elsa <= elsa_nxt;
         end
      end
   end

   // Entry must not race a mode write decided in the execution unit
   a_exp_ent_rm: assert property (@(posedge clk) disable iff (!rst_n)
      !(exp_ent && psr_rm_we));

   a_we_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown({psr_cc_we, psr_rm_we, psr_ire_we, psr_imme_we, psr_dmme_we,
                   epsr_we, epc_we, elsa_we, exp_ent}));

endmodule : psr_regs

`default_nettype wire

/* tlb_regs.sv */
/* TLB low and high word arrays with indexed write and
   combinational read, one instance per MMU */
`default_nettype none

module tlb_regs
   import msr_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic [tlb_aw-1:0] idx,
   input  wire logic [dw-1:0]     wdat,
   input  wire logic              tlbl_we,
   input  wire logic              tlbh_we,
   output logic [dw-1:0]          tlbl,
   output logic [dw-1:0]          tlbh
);

   logic [dw-1:0] lo_mem [tlb_n];
   logic [dw-1:0] hi_mem [tlb_n];

   // Entries come up invalid, so the arrays are cleared
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < tlb_n; i++) begin
            lo_mem[i] <= '0;
            hi_mem[i] <= '0;
         end
      end else begin
         if (tlbl_we) begin
            lo_mem[idx] <= wdat;
         end
         if (tlbh_we) begin
            hi_mem[idx] <= wdat;
         end
      end
   end

   assign tlbl = lo_mem[idx];
   assign tlbh = hi_mem[idx];

   // One MSR write selects a single word
   a_one_word: assert property (@(posedge clk) disable iff (!rst_n)
      !(tlbl_we && tlbh_we));

endmodule : tlb_regs

`default_nettype wire

/* msr_unit.sv */
/* MSR subsystem top: execution unit, status registers
   and the instruction and data TLB arrays */
`default_nettype none

module msr_unit
   import msr_pkg::*;
(
   input  wire logic            clk,
   input  wire logic            rst_n,
   input  wire logic            rmsr,
   input  wire logic            wmsr,
   input  wire logic [dw-1:0]   operand_1,
   input  wire logic [dw-1:0]   operand_2,
   input  wire logic [dw-1:0]   operand_3,
   input  wire logic            commit,
   input  wire logic            cc_we,
   input  wire logic            cc_nxt,
   input  wire logic            ret,
   input  wire logic            syscall,
   input  wire logic            specul_extexp,
   input  wire logic            let_lsa_pc,
   input  wire logic [pc_w-1:0] insn_pc,
   input  wire logic [dw-1:0]   linkaddr,
   output logic                 dout_op,
   output logic [dw-1:0]        dout,
   output logic [psr_dw-1:0]    psr,
   output logic                 exp_ent
);

   logic              psr_cc_nxt;
   logic              psr_cc_we;
   logic              psr_rm_nxt;
   logic              psr_rm_we;
   logic              psr_ire_nxt;
   logic              psr_ire_we;
   logic              psr_imme_nxt;
   logic              psr_imme_we;
   logic              psr_dmme_nxt;
   logic              psr_dmme_we;
   logic [psr_dw-1:0] epsr;
   logic [psr_dw-1:0] epsr_nxt;
   logic              epsr_we;
   logic [dw-1:0]     epc;
   logic [dw-1:0]     epc_nxt;
   logic              epc_we;
   logic [dw-1:0]     elsa;
   logic [dw-1:0]     elsa_nxt;
   logic              elsa_we;
   logic [tlb_aw-1:0] tlb_idx;
   logic [dw-1:0]     tlb_wdat;
   logic [dw-1:0]     itlbl;
   logic [dw-1:0]     itlbh;
   logic [dw-1:0]     dtlbl;
   logic [dw-1:0]     dtlbh;
   logic              itlbl_we;
   logic              itlbh_we;
   logic              dtlbl_we;
   logic              dtlbh_we;

   msr_eu u_eu (.*);

   psr_regs u_psr (.*);

   // Both MMUs share index and write data, only the enables differ
   tlb_regs u_itlb (
      .clk     (clk),
      .rst_n   (rst_n),
      .idx     (tlb_idx),
      .wdat    (tlb_wdat),
      .tlbl_we (itlbl_we),
      .tlbh_we (itlbh_we),
      .tlbl    (itlbl),
      .tlbh    (itlbh)
   );

   tlb_regs u_dtlb (
      .clk     (clk),
      .rst_n   (rst_n),
      .idx     (tlb_idx),
      .wdat    (tlb_wdat),
      .tlbl_we (dtlbl_we),
      .tlbh_we (dtlbh_we),
      .tlbl    (dtlbl),
      .tlbh    (dtlbh)
   );

endmodule : msr_unit

`default_nettype wire

/* tb_msr_unit.sv */
/* Testbench for the MSR subsystem: clock and reset, shadow register
   model, reference read function, checker, watchdog and test sequence */
`default_nettype none

module tb_msr_unit
   import msr_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int n_rounds   = 4;
   localparam int tlb_writes = 32;
   // Operations issued by the sequence below, plus reset and tail
   localparam int op_count   = 13 + 8 * tlb_n + tlb_writes + 33 * n_rounds + 3;
   localparam int limit_ns   = (op_count + 20) * 100;

   logic              clk;
   logic              rst_n;
   logic              rmsr;
   logic              wmsr;
   logic [dw-1:0]     operand_1;
   logic [dw-1:0]     operand_2;
   logic [dw-1:0]     operand_3;
   logic              commit;
   logic              cc_we;
   logic              cc_nxt;
   logic              ret;
   logic              syscall;
   logic              specul_extexp;
   logic              let_lsa_pc;
   logic [pc_w-1:0]   insn_pc;
   logic [dw-1:0]     linkaddr;
   logic              dout_op;
   logic [dw-1:0]     dout;
   logic [psr_dw-1:0] psr;
   logic              exp_ent;

   // Shadow copy of the architectural state
   logic [psr_dw-1:0] sh_psr;
   logic [psr_dw-1:0] sh_epsr;
   logic [dw-1:0]     sh_epc;
   logic [dw-1:0]     sh_elsa;
   logic [dw-1:0]     sh_itlbl [tlb_n];
   logic [dw-1:0]     sh_itlbh [tlb_n];
   logic [dw-1:0]     sh_dtlbl [tlb_n];
   logic [dw-1:0]     sh_dtlbh [tlb_n];
   int                errors;

   msr_unit u_dut (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   initial begin
      #(limit_ns);
      $display("Watchdog expired before the test sequence finished");
      $display("Testbench failed");
      $fatal(1, "Simulation timeout");
   end

   task automatic check(input logic [dw-1:0] got, input logic [dw-1:0] exp,
                        input string what);
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Testbench failed");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // Only cc, rm, ire, imme and dmme exist in the PSR
   function automatic logic [psr_dw-1:0] field_mask();
      logic [psr_dw-1:0] m;
      m           = '0;
      m[psr_cc]   = 1'b1;
      m[psr_rm]   = 1'b1;
      m[psr_ire]  = 1'b1;
      m[psr_imme] = 1'b1;
      m[psr_dmme] = 1'b1;
      return m;
   endfunction

   function automatic logic [dw-1:0] ref_read(input logic [dw-1:0] addr);
      logic [bank_aw-1:0]     b;
      logic [bank_off_aw-1:0] o;
      logic [tlb_aw-1:0]      i;
      logic [dw-1:0]          r;
      b = addr[bank_off_aw +: bank_aw];
      o = addr[bank_off_aw-1:0];
      i = o[tlb_aw-1:0];
      r = '0;
      if (b == bank_ps) begin
         // Several one-hot bits set give the OR of the registers
         if (o[off_psr])    r |= dw'(sh_psr);
         if (o[off_cpuid])  r |= cpuid_val;
         if (o[off_epsr])   r |= dw'(sh_epsr);
         if (o[off_epc])    r |= sh_epc;
         if (o[off_elsa])   r |= sh_elsa;
         if (o[off_coreid]) r |= coreid_val;
      end else if (b == bank_imm || b == bank_dmm) begin
         if (!o[off_tlbsel]) begin
            r = (b == bank_imm) ? immid_val : dmmid_val;
         end else if (o[off_tlbh_sel]) begin
            r = (b == bank_imm) ? sh_itlbh[i] : sh_dtlbh[i];
         end else begin
            r = (b == bank_imm) ? sh_itlbl[i] : sh_dtlbl[i];
         end
      end
      return r;
   endfunction

   task automatic reset_shadow();
      sh_psr  = psr_rst;
      sh_epsr = '0;
      sh_epc  = '0;
      sh_elsa = '0;
      for (int k = 0; k < tlb_n; k++) begin
         sh_itlbl[k] = '0;
         sh_itlbh[k] = '0;
         sh_dtlbl[k] = '0;
         sh_dtlbh[k] = '0;
      end
   endtask

   // Compare at the falling edge, then advance the shadow to the next rising edge
   always @(negedge clk) begin : compare_and_track
      logic [dw-1:0]          a;
      logic [bank_aw-1:0]     b;
      logic [bank_off_aw-1:0] o;
      logic [tlb_aw-1:0]      i;
      logic [dw-1:0]          pc_b;
      logic                   ent;
      logic                   wps;
      logic [psr_dw-1:0]      nxt_psr;
      a    = operand_1 + operand_2;
      b    = a[bank_off_aw +: bank_aw];
      o    = a[bank_off_aw-1:0];
      i    = o[tlb_aw-1:0];
      pc_b = {insn_pc, 2'b00};
      ent  = syscall || specul_extexp;
      wps  = wmsr && (b == bank_ps);
      if (rst_n !== 1'b1) begin
         reset_shadow();
      end else begin
         check(32'(dout_op), 32'(rmsr), "dout_op");
         check(32'(exp_ent), 32'(commit && ent), "exp_ent");
         check(dw'(psr), dw'(sh_psr), "psr");
         if (rmsr) begin
            check(dout, ref_read(a), "dout");
         end
         if (commit) begin
            nxt_psr = sh_psr;
            if (cc_we) begin
               nxt_psr[psr_cc] = cc_nxt;
            end else if (wps && o[off_psr]) begin
               nxt_psr = operand_3[psr_dw-1:0] & field_mask();
            end else if (ret) begin
               nxt_psr = sh_epsr & field_mask();
            end
            if (ent) begin
               nxt_psr[psr_rm]   = 1'b1;
               nxt_psr[psr_ire]  = 1'b0;
               nxt_psr[psr_imme] = 1'b0;
               nxt_psr[psr_dmme] = 1'b0;
            end
            if (wps && o[off_epsr]) begin
               sh_epsr = operand_3[psr_dw-1:0];
            end else if (ent) begin
               sh_epsr = sh_psr;
            end
            if (wps && o[off_epc]) begin
               sh_epc = operand_3;
            end else if (specul_extexp) begin
               sh_epc = pc_b;
            end else if (syscall) begin
               sh_epc = linkaddr;
            end
            if (let_lsa_pc) begin
               sh_elsa = pc_b;
            end else if (wps && o[off_elsa]) begin
               sh_elsa = operand_3;
            end
            if (wmsr && o[off_tlbsel]) begin
               if (b == bank_imm && o[off_tlbh_sel])  sh_itlbh[i] = operand_3;
               if (b == bank_imm && !o[off_tlbh_sel]) sh_itlbl[i] = operand_3;
               if (b == bank_dmm && o[off_tlbh_sel])  sh_dtlbh[i] = operand_3;
               if (b == bank_dmm && !o[off_tlbh_sel]) sh_dtlbl[i] = operand_3;
            end
            sh_psr = nxt_psr;
         end
      end
   end

   function automatic logic [dw-1:0] addr_of(input logic [bank_aw-1:0] b,
                                             input logic [bank_off_aw-1:0] o);
      return dw'({b, o});
   endfunction

   function automatic logic [dw-1:0] ps_addr(input int unsigned bitpos);
      return addr_of(bank_ps, bank_off_aw'(1) << bitpos);
   endfunction

   function automatic logic [dw-1:0] tlb_addr(input logic [bank_aw-1:0] b, input logic hi,
                                              input logic [tlb_aw-1:0] idx);
      logic [bank_off_aw-1:0] o;
      o                 = '0;
      o[off_tlbsel]     = 1'b1;
      o[off_tlbh_sel]   = hi;
      o[tlb_aw-1:0]     = idx;
      return addr_of(b, o);
   endfunction

   task automatic clear_inputs();
      rmsr          = 1'b0;
      wmsr          = 1'b0;
      operand_1     = '0;
      operand_2     = '0;
      operand_3     = '0;
      commit        = 1'b0;
      cc_we         = 1'b0;
      cc_nxt        = 1'b0;
      ret           = 1'b0;
      syscall       = 1'b0;
      specul_extexp = 1'b0;
      let_lsa_pc    = 1'b0;
      insn_pc       = '0;
      linkaddr      = '0;
   endtask

   task automatic start_cycle();
      @(posedge clk);
      #5;
      clear_inputs();
   endtask

   // Random split of the address over both operands
   task automatic put_addr(input logic [dw-1:0] addr);
      operand_1 = $urandom;
      operand_2 = addr - operand_1;
   endtask

   task automatic read_msr(input logic [dw-1:0] addr);
      start_cycle();
      rmsr   = 1'b1;
      commit = 1'b1;
      put_addr(addr);
   endtask

   task automatic write_msr(input logic [dw-1:0] addr, input logic [dw-1:0] data,
                            input logic cm);
      start_cycle();
      wmsr      = 1'b1;
      commit    = cm;
      operand_3 = data;
      put_addr(addr);
   endtask

   task automatic raise_exception(input logic ext);
      start_cycle();
      commit        = 1'b1;
      syscall       = ~ext;
      specul_extexp = ext;
      insn_pc       = pc_w'($urandom);
      linkaddr      = $urandom;
   endtask

   task automatic return_from_exception();
      start_cycle();
      commit = 1'b1;
      ret    = 1'b1;
   endtask

   task automatic update_flag(input logic v);
      start_cycle();
      commit = 1'b1;
      cc_we  = 1'b1;
      cc_nxt = v;
   endtask

   task automatic capture_fault_addr();
      start_cycle();
      commit     = 1'b1;
      let_lsa_pc = 1'b1;
      insn_pc    = pc_w'($urandom);
      operand_3  = $urandom;
   endtask

   task automatic read_status_regs();
      read_msr(ps_addr(off_psr));
      read_msr(ps_addr(off_cpuid));
      read_msr(ps_addr(off_epsr));
      read_msr(ps_addr(off_epc));
      read_msr(ps_addr(off_elsa));
      read_msr(ps_addr(off_coreid));
   endtask

   task automatic read_all_tlbs();
      for (int k = 0; k < tlb_n; k++) begin
         read_msr(tlb_addr(bank_imm, 1'b0, tlb_aw'(k)));
         read_msr(tlb_addr(bank_imm, 1'b1, tlb_aw'(k)));
         read_msr(tlb_addr(bank_dmm, 1'b0, tlb_aw'(k)));
         read_msr(tlb_addr(bank_dmm, 1'b1, tlb_aw'(k)));
      end
   endtask

   initial begin
      errors = 0;
      rst_n  = 1'b0;
      clear_inputs();
      void'($urandom(32'h3828));
      repeat (2) @(posedge clk);
      #5;
      rst_n = 1'b1;

      // Reset values, id words and unmapped banks
      read_status_regs();
      read_msr(addr_of(bank_imm, '0));
      read_msr(addr_of(bank_dmm, '0));
      read_all_tlbs();
      for (int b = int'(bank_ica); b <= int'(bank_tsc); b++) begin
         read_msr(addr_of(bank_aw'(b), bank_off_aw'($urandom)));
      end

      // Status register writes, each read back in the next cycle
      for (int r = 0; r < n_rounds; r++) begin
         write_msr(ps_addr(off_psr), $urandom, 1'b1);
         read_msr(ps_addr(off_psr));
         write_msr(ps_addr(off_epsr), $urandom, 1'b1);
         read_msr(ps_addr(off_epsr));
         write_msr(ps_addr(off_epc), $urandom, 1'b1);
         read_msr(ps_addr(off_epc));
         write_msr(ps_addr(off_elsa), $urandom, 1'b1);
         read_msr(ps_addr(off_elsa));
         write_msr(ps_addr(off_psr), $urandom, 1'b0);
         read_msr(ps_addr(off_psr));
         write_msr(ps_addr(off_epsr), $urandom, 1'b0);
         read_msr(ps_addr(off_epsr));
         write_msr(ps_addr(off_epc), $urandom, 1'b0);
         read_msr(ps_addr(off_epc));
         write_msr(ps_addr(off_elsa), $urandom, 1'b0);
         read_msr(ps_addr(off_elsa));
      end

      // TLB words at random indices
      for (int w = 0; w < tlb_writes; w++) begin
         write_msr(tlb_addr(($urandom % 2 == 0) ? bank_imm : bank_dmm, 1'($urandom),
                            tlb_aw'($urandom)), $urandom, 1'b1);
      end
      read_all_tlbs();

      // Exception entry from syscall and from an external exception
      for (int r = 0; r < n_rounds; r++) begin
         for (int c = 0; c < 2; c++) begin
            write_msr(ps_addr(off_psr), $urandom, 1'b1);
            raise_exception(1'(c));
            read_msr(ps_addr(off_epsr));
            read_msr(ps_addr(off_epc));
            read_msr(ps_addr(off_psr));
         end
      end

      // Return restores from EPSR, flag update touches cc only
      for (int r = 0; r < n_rounds; r++) begin
         write_msr(ps_addr(off_epsr), $urandom, 1'b1);
         return_from_exception();
         read_msr(ps_addr(off_psr));
         update_flag(1'($urandom));
         read_msr(ps_addr(off_psr));
      end

      // Load/store fault address
      for (int r = 0; r < n_rounds; r++) begin
         capture_fault_addr();
         read_msr(ps_addr(off_elsa));
      end

      start_cycle();
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule : tb_msr_unit

`default_nettype wire

/* msr_unit.f */
msr_pkg.sv
msr_eu.sv
psr_regs.sv
tlb_regs.sv
msr_unit.sv
tb_msr_unit.sv

/* Makefile */
# Verilator flow for the MSR subsystem

TB_TOP = tb_msr_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f msr_unit.f --top-module msr_unit

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f msr_unit.f --top-module $(TB_TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TB_TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
